//--- common/rv_exe_params.svh
// ----------------------------------------------------------------------
// Execute stage constants: data width, RV64I opcodes, funct3 codes
// ----------------------------------------------------------------------
`ifndef RV_EXE_PARAMS_SVH
`define RV_EXE_PARAMS_SVH

`define RV_XLEN 64

// Major opcodes, inst[6:0]
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_OPIMM   7'b0010011
`define OPC_OP      7'b0110011
`define OPC_OPIMM32 7'b0011011
`define OPC_OP32    7'b0111011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_CSR     7'b1110011

// ALU funct3, shared by OP / OP-IMM and the 32-bit forms
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101  // SRL or SRA by funct7[5]
`define F3_OR   3'b110
`define F3_AND  3'b111

// Branch conditions
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`endif

//--- common/rv_exe_pkg.sv
// ----------------------------------------------------------------------
// Execute stage types: request, ALU and branch results, stage output
// ----------------------------------------------------------------------
`include "rv_exe_params.svh"

package rv_exe_pkg;

  // Decoded instruction as seen by the execute stage
  typedef struct packed {
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] op1;
    logic [`RV_XLEN-1:0] op2;
    logic [`RV_XLEN-1:0] t1;       // Branch target or link value
    logic [`RV_XLEN-1:0] pc_pred;  // Predicted next pc
    logic                memren;
    logic                memwen;
  } exe_req_t;

  typedef struct packed {
    logic                rd_wen;
    logic [`RV_XLEN-1:0] rd_data;
  } alu_res_t;

  typedef struct packed {
    logic                taken;
    logic [`RV_XLEN-1:0] target;
  } br_res_t;

  typedef struct packed {
    logic                rd_wen;
    logic [`RV_XLEN-1:0] rd_data;
    logic                redirect;       // Fetch must restart
    logic [`RV_XLEN-1:0] redirect_addr;
    logic                memren;
    logic                memwen;
  } exe_out_t;

endpackage

//--- source/pipe_reg.sv
// ----------------------------------------------------------------------
// Single pipeline register with valid and generic payload
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module pipe_reg #(
  parameter type T = logic
) (
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_valid,
  input  T     i_data,
  output logic o_valid,
  output T     o_data
);

  // No stall, loads every cycle
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
      o_data  <= '0;
    end else begin
      o_valid <= i_valid;
      o_data  <= i_data;
    end
  end

endmodule

//--- exe/alu_unit.sv
// ----------------------------------------------------------------------
// Integer ALU: add/sub, logic, shifts, compares, 32-bit word forms
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "rv_exe_params.svh"

module alu_unit (
  input  rv_exe_pkg::exe_req_t i_req,
  output rv_exe_pkg::alu_res_t o_res
);

  logic [`RV_XLEN-1:0] op1;
  logic [`RV_XLEN-1:0] op2;
  logic [5:0]          shamt;
  logic                sub64;
  logic                sub32;
  logic                arith_sh;
  logic [`RV_XLEN-1:0] sum64;
  logic [`RV_XLEN-1:0] sra64;
  logic [`RV_XLEN-1:0] slt64;
  logic [`RV_XLEN-1:0] sltu64;
  logic [31:0]         w_sum;
  logic [31:0]         w_sll;
  logic [31:0]         w_srl;
  logic [31:0]         w_sra;

  function automatic logic [`RV_XLEN-1:0] sext32(input logic [31:0] v);
    return {{(`RV_XLEN-32){v[31]}}, v};
  endfunction

  assign op1      = i_req.op1;
  assign op2      = i_req.op2;
  assign shamt    = op2[5:0];
  assign arith_sh = i_req.funct7[5];

  // SUB only exists in the register forms
  assign sub64 = (i_req.opcode == `OPC_OP) && i_req.funct7[5];
  assign sub32 = (i_req.opcode == `OPC_OP32) && i_req.funct7[5];

  assign sum64  = sub64 ? (op1 - op2) : (op1 + op2);
  assign sra64  = $signed(op1) >>> shamt;
  assign slt64  = {{(`RV_XLEN-1){1'b0}}, ($signed(op1) < $signed(op2))};
  assign sltu64 = {{(`RV_XLEN-1){1'b0}}, (op1 < op2)};

  // Word results before sign extension
  assign w_sum = sub32 ? (op1[31:0] - op2[31:0]) : (op1[31:0] + op2[31:0]);
  assign w_sll = op1[31:0] << op2[4:0];
  assign w_srl = op1[31:0] >> op2[4:0];
  assign w_sra = $signed(op1[31:0]) >>> op2[4:0];

  always_comb begin
    case (i_req.opcode)
      `OPC_LUI, `OPC_AUIPC, `OPC_OPIMM, `OPC_OP,
      `OPC_OPIMM32, `OPC_OP32, `OPC_JAL, `OPC_JALR,
      `OPC_LOAD, `OPC_CSR: o_res.rd_wen = 1'b1;
      default:             o_res.rd_wen = 1'b0;
    endcase
  end

  always_comb begin
    o_res.rd_data = '0;
    case (i_req.opcode)
      `OPC_LUI, `OPC_JAL, `OPC_CSR: o_res.rd_data = op1;  // CSR value passes through
      `OPC_AUIPC:                   o_res.rd_data = op1 + op2;
      `OPC_JALR:                    o_res.rd_data = i_req.t1;
      `OPC_OPIMM, `OPC_OP: begin
        case (i_req.funct3)
          `F3_ADD:  o_res.rd_data = sum64;
          `F3_SLL:  o_res.rd_data = op1 << shamt;
          `F3_SLT:  o_res.rd_data = slt64;
          `F3_SLTU: o_res.rd_data = sltu64;
          `F3_XOR:  o_res.rd_data = op1 ^ op2;
          `F3_SR:   o_res.rd_data = arith_sh ? sra64 : (op1 >> shamt);
          `F3_OR:   o_res.rd_data = op1 | op2;
          `F3_AND:  o_res.rd_data = op1 & op2;
          default:  o_res.rd_data = '0;
        endcase
      end
      `OPC_OPIMM32, `OPC_OP32: begin
        case (i_req.funct3)
          `F3_ADD: o_res.rd_data = sext32(w_sum);
          `F3_SLL: o_res.rd_data = sext32(w_sll);
          `F3_SR:  o_res.rd_data = arith_sh ? sext32(w_sra) : sext32(w_srl);
          default: o_res.rd_data = '0;
        endcase
      end
      default: o_res.rd_data = '0;
    endcase
  end

endmodule

//--- exe/branch_unit.sv
// ----------------------------------------------------------------------
// Jump and conditional branch resolver: taken flag and target
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "rv_exe_params.svh"

module branch_unit (
  input  rv_exe_pkg::exe_req_t i_req,
  output rv_exe_pkg::br_res_t  o_res
);

  logic                eq;
  logic                lt_s;
  logic                lt_u;
  logic                cond;
  logic [`RV_XLEN-1:0] jalr_sum;

  assign eq       = (i_req.op1 == i_req.op2);
  assign lt_s     = ($signed(i_req.op1) < $signed(i_req.op2));
  assign lt_u     = (i_req.op1 < i_req.op2);
  assign jalr_sum = i_req.op1 + i_req.op2;

  // Branch condition by funct3
  always_comb begin
    case (i_req.funct3)
      `F3_BEQ:  cond = eq;
      `F3_BNE:  cond = !eq;
      `F3_BLT:  cond = lt_s;
      `F3_BGE:  cond = !lt_s;
      `F3_BLTU: cond = lt_u;
      `F3_BGEU: cond = !lt_u;
      default:  cond = 1'b0;
    endcase
  end

  always_comb begin
    o_res.taken  = 1'b0;
    o_res.target = '0;
    case (i_req.opcode)
      `OPC_JAL: begin
        o_res.taken  = 1'b1;
        o_res.target = i_req.op2;  // Already pc + imm
      end
      `OPC_JALR: begin
        o_res.taken  = 1'b1;
        o_res.target = {jalr_sum[`RV_XLEN-1:1], 1'b0};
      end
      `OPC_BRANCH: begin
        o_res.taken  = cond;
        o_res.target = i_req.t1;
      end
      default: begin
        o_res.taken  = 1'b0;
        o_res.target = '0;
      end
    endcase
  end

endmodule

//--- exe/exe_result_merge.sv
// ----------------------------------------------------------------------
// Result merge: valid gating, memory enables, redirect check
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module exe_result_merge (
  input  logic                 i_valid,
  input  rv_exe_pkg::exe_req_t i_req,
  input  rv_exe_pkg::alu_res_t i_alu,
  input  rv_exe_pkg::br_res_t  i_br,
  output rv_exe_pkg::exe_out_t o_out
);

  logic mispredict;

  // Only taken jumps are checked against the prediction
  assign mispredict = i_br.taken && (i_br.target != i_req.pc_pred);

  always_comb begin
    o_out = '0;
    if (i_valid) begin
      o_out.rd_wen   = i_alu.rd_wen;
      o_out.rd_data  = i_alu.rd_data;
      o_out.memren   = i_req.memren;
      o_out.memwen   = i_req.memwen;
      o_out.redirect = mispredict;
      if (mispredict) begin
        o_out.redirect_addr = i_br.target;
      end
    end
  end

endmodule

//--- source/exe_top.sv
// ----------------------------------------------------------------------
// Execute stage top: request reg, ALU, branch unit, merge, output reg
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module exe_top (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_valid,
  input  rv_exe_pkg::exe_req_t i_req,
  output logic                 o_valid,
  output rv_exe_pkg::exe_out_t o_out
);

  logic                 req_valid;
  rv_exe_pkg::exe_req_t req;
  rv_exe_pkg::alu_res_t alu_res;
  rv_exe_pkg::br_res_t  br_res;
  rv_exe_pkg::exe_out_t merge_out;

  pipe_reg #(.T(rv_exe_pkg::exe_req_t)) u_req_reg (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .i_data  (i_req),
    .o_valid (req_valid),
    .o_data  (req)
  );

  alu_unit u_alu (
    .i_req (req),
    .o_res (alu_res)
  );

  branch_unit u_br (
    .i_req (req),
    .o_res (br_res)
  );

  exe_result_merge u_merge (
    .i_valid (req_valid),
    .i_req   (req),
    .i_alu   (alu_res),
    .i_br    (br_res),
    .o_out   (merge_out)
  );

  // Second stage, fixed two-cycle latency overall
  pipe_reg #(.T(rv_exe_pkg::exe_out_t)) u_out_reg (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_valid (req_valid),
    .i_data  (merge_out),
    .o_valid (o_valid),
    .o_data  (o_out)
  );

endmodule

//--- dv/exe_tb.sv
// ----------------------------------------------------------------------
// Directed testbench for exe_top: ALU, jumps, branches, pipelining
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "rv_exe_params.svh"

module exe_tb;

  localparam int CLK_PERIOD     = 20;
  localparam int NUM_TESTS      = 6;
  localparam int REQS_PER_TEST  = 40;  // Upper bound over all tests
  localparam int CYCLES_PER_REQ = 3;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * REQS_PER_TEST * CYCLES_PER_REQ + 20;

  logic                 i_clk;
  logic                 i_reset;
  logic                 i_valid;
  rv_exe_pkg::exe_req_t i_req;
  logic                 o_valid;
  rv_exe_pkg::exe_out_t o_out;
  integer               seed;

  exe_top i_dut (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .i_req   (i_req),
    .o_valid (o_valid),
    .o_out   (o_out)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    stop_run();
  end

  function automatic logic [`RV_XLEN-1:0] ext1(input logic b);
    return {{(`RV_XLEN-1){1'b0}}, b};
  endfunction

  function automatic logic [`RV_XLEN-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic rv_exe_pkg::exe_req_t make_req(
    input logic [6:0]          opc,
    input logic [2:0]          f3,
    input logic [6:0]          f7,
    input logic [`RV_XLEN-1:0] a,
    input logic [`RV_XLEN-1:0] b,
    input logic [`RV_XLEN-1:0] t1,
    input logic [`RV_XLEN-1:0] pc_pred
  );
    rv_exe_pkg::exe_req_t r;
    r         = '0;
    r.opcode  = opc;
    r.funct3  = f3;
    r.funct7  = f7;
    r.op1     = a;
    r.op2     = b;
    r.t1      = t1;
    r.pc_pred = pc_pred;
    return r;
  endfunction

  // Expected stage output for one request
  function automatic rv_exe_pkg::exe_out_t ref_out(input logic valid,
                                                   input rv_exe_pkg::exe_req_t r);
    rv_exe_pkg::exe_out_t o;
    logic [`RV_XLEN-1:0]  a;
    logic [`RV_XLEN-1:0]  b;
    logic [`RV_XLEN-1:0]  sra;
    logic [`RV_XLEN-1:0]  tgt;
    logic [31:0]          w;
    logic [31:0]          wsra;
    logic                 taken;
    o     = '0;
    w     = '0;
    tgt   = '0;
    taken = 1'b0;
    a     = r.op1;
    b     = r.op2;
    sra   = $signed(a) >>> b[5:0];
    wsra  = $signed(a[31:0]) >>> b[4:0];
    o.rd_wen = r.opcode inside {`OPC_LUI, `OPC_AUIPC, `OPC_OPIMM, `OPC_OP, `OPC_OPIMM32,
                                `OPC_OP32, `OPC_JAL, `OPC_JALR, `OPC_LOAD, `OPC_CSR};
    case (r.opcode)
      `OPC_LUI, `OPC_JAL, `OPC_CSR: o.rd_data = a;
      `OPC_AUIPC: o.rd_data = a + b;
      `OPC_JALR:  o.rd_data = r.t1;
      `OPC_OP, `OPC_OPIMM: begin
        case (r.funct3)
          `F3_ADD:  o.rd_data = (r.opcode == `OPC_OP && r.funct7[5]) ? a - b : a + b;
          `F3_SLL:  o.rd_data = a << b[5:0];
          `F3_SLT:  o.rd_data = ext1($signed(a) < $signed(b));
          `F3_SLTU: o.rd_data = ext1(a < b);
          `F3_XOR:  o.rd_data = a ^ b;
          `F3_OR:   o.rd_data = a | b;
          `F3_AND:  o.rd_data = a & b;
          `F3_SR: begin
            if (r.funct7[5]) begin
              o.rd_data = sra;
            end else begin
              o.rd_data = a >> b[5:0];
            end
          end
          default:  o.rd_data = '0;
        endcase
      end
      `OPC_OP32, `OPC_OPIMM32: begin
        case (r.funct3)
          `F3_ADD: w = (r.opcode == `OPC_OP32 && r.funct7[5]) ? a[31:0] - b[31:0]
                                                               : a[31:0] + b[31:0];
          `F3_SLL: w = a[31:0] << b[4:0];
          `F3_SR:  w = r.funct7[5] ? wsra : a[31:0] >> b[4:0];
          default: w = '0;
        endcase
        o.rd_data = {{(`RV_XLEN-32){w[31]}}, w};
      end
      default: o.rd_data = '0;
    endcase
    case (r.opcode)
      `OPC_JAL: begin
        taken = 1'b1;
        tgt   = b;
      end
      `OPC_JALR: begin
        taken  = 1'b1;
        tgt    = a + b;
        tgt[0] = 1'b0;
      end
      `OPC_BRANCH: begin
        tgt = r.t1;
        case (r.funct3)
          `F3_BEQ:  taken = (a == b);
          `F3_BNE:  taken = (a != b);
          `F3_BLT:  taken = ($signed(a) < $signed(b));
          `F3_BGE:  taken = ($signed(a) >= $signed(b));
          `F3_BLTU: taken = (a < b);
          `F3_BGEU: taken = (a >= b);
          default:  taken = 1'b0;
        endcase
      end
      default: taken = 1'b0;
    endcase
    if (taken && (tgt != r.pc_pred)) begin
      o.redirect      = 1'b1;
      o.redirect_addr = tgt;
    end
    o.memren = r.memren;
    o.memwen = r.memwen;
    if (!valid) begin
      o = '0;
    end
    return o;
  endfunction

  task automatic check_val(input string test, input string field,
                           input logic [`RV_XLEN-1:0] exp, input logic [`RV_XLEN-1:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h", test, field, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_out(input string test, input logic exp_valid,
                             input rv_exe_pkg::exe_out_t exp);
    if (o_valid !== exp_valid) begin
      $display("Test %s: o_valid is %b two cycles after the request, %b was expected",
               test, o_valid, exp_valid);
      stop_run();
    end else begin
      check_val(test, "rd_wen", ext1(exp.rd_wen), ext1(o_out.rd_wen));
      check_val(test, "rd_data", exp.rd_data, o_out.rd_data);
      check_val(test, "redirect", ext1(exp.redirect), ext1(o_out.redirect));
      check_val(test, "redirect_addr", exp.redirect_addr, o_out.redirect_addr);
      check_val(test, "memren", ext1(exp.memren), ext1(o_out.memren));
      check_val(test, "memwen", ext1(exp.memwen), ext1(o_out.memwen));
    end
  endtask

  // One request, then idle until its result shows
  task automatic run_req(input string test, input logic valid, input rv_exe_pkg::exe_req_t r);
    rv_exe_pkg::exe_out_t exp;
    exp = ref_out(valid, r);
    @(posedge i_clk);
    #2;
    i_valid = valid;
    i_req   = r;
    @(posedge i_clk);
    #2;
    i_valid = 1'b0;
    i_req   = '0;
    @(posedge i_clk);
    #2;
    compare_out(test, valid, exp);
  endtask

  task automatic test_reset();
    rv_exe_pkg::exe_req_t r;
    compare_out("reset", 1'b0, '0);
    r        = make_req(`OPC_JAL, 3'd0, 7'd0, 64'h1004, 64'h2000, '0, 64'h1004);
    r.memren = 1'b1;
    run_req("reset_invalid", 1'b0, r);
  endtask

  task automatic test_alu64();
    logic [2:0] f3 [10] = '{`F3_ADD, `F3_ADD, `F3_SLT, `F3_SLTU, `F3_XOR,
                            `F3_OR, `F3_AND, `F3_SLL, `F3_SR, `F3_SR};
    logic [6:0] f7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                            7'h00, 7'h00, 7'h00, 7'h00, 7'h20};
    for (int i = 0; i < 10; i++) begin
      run_req("alu64_op", 1'b1, make_req(`OPC_OP, f3[i], f7[i], rand64(), rand64(), '0, '0));
      run_req("alu64_opimm", 1'b1,
              make_req(`OPC_OPIMM, f3[i], f7[i], rand64(), rand64(), '0, '0));
    end
    run_req("lui", 1'b1, make_req(`OPC_LUI, 3'd0, 7'd0, rand64(), '0, '0, '0));
    run_req("auipc", 1'b1, make_req(`OPC_AUIPC, 3'd0, 7'd0, 64'h8000_1000, rand64(), '0, '0));
  endtask

  task automatic test_alu32();
    logic [2:0]          f3 [5] = '{`F3_ADD, `F3_ADD, `F3_SLL, `F3_SR, `F3_SR};
    logic [6:0]          f7 [5] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h20};
    logic [`RV_XLEN-1:0] a;
    logic [6:0]          opc;
    for (int i = 0; i < 5; i++) begin
      for (int k = 0; k < 3; k++) begin
        a   = rand64();
        opc = (k == 1) ? `OPC_OPIMM32 : `OPC_OP32;
        if (k == 2) begin
          a[31] = 1'b1;  // Negative low word
        end
        run_req("alu32", 1'b1, make_req(opc, f3[i], f7[i], a, rand64(), '0, '0));
      end
    end
  endtask

  task automatic test_jumps();
    run_req("jal_match", 1'b1, make_req(`OPC_JAL, 3'd0, 7'd0, 64'h1004, 64'h3000, '0, 64'h3000));
    run_req("jal_mismatch", 1'b1,
            make_req(`OPC_JAL, 3'd0, 7'd0, 64'h1004, 64'h3000, '0, 64'h1004));
    run_req("jalr_match", 1'b1,
            make_req(`OPC_JALR, 3'd0, 7'd0, 64'h4000, 64'h10, 64'h2008, 64'h4010));
    // Odd sum, bit 0 of the target must clear
    run_req("jalr_mismatch", 1'b1,
            make_req(`OPC_JALR, 3'd0, 7'd0, 64'h1000_0001, 64'h20, 64'h2008, 64'h2000));
  endtask

  task automatic test_branches();
    logic [2:0]          f3 [6] = '{`F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE, `F3_BLTU, `F3_BGEU};
    logic [`RV_XLEN-1:0] a [3];
    logic [`RV_XLEN-1:0] b [3];
    a[0] = 64'h1234_5678;          // Equal
    b[0] = 64'h1234_5678;
    a[1] = 64'hffff_ffff_ffff_fff0; // Signed less, unsigned greater
    b[1] = 64'h10;
    a[2] = 64'h10;                 // Unsigned less, signed greater
    b[2] = 64'h8000_0000_0000_0000;
    for (int i = 0; i < 6; i++) begin
      for (int k = 0; k < 3; k++) begin
        run_req("branch", 1'b1, make_req(`OPC_BRANCH, f3[i], 7'd0, a[k], b[k],
                                         64'h5000, 64'h1004));
      end
    end
    run_req("branch_predicted", 1'b1,
            make_req(`OPC_BRANCH, `F3_BEQ, 7'd0, a[0], b[0], 64'h5000, 64'h5000));
  endtask

  task automatic test_back_to_back();
    logic [6:0]           ops [8] = '{`OPC_OP, `OPC_OPIMM32, `OPC_JAL, `OPC_BRANCH,
                                      `OPC_LOAD, `OPC_STORE, `OPC_LUI, `OPC_JALR};
    rv_exe_pkg::exe_req_t reqs [8];
    rv_exe_pkg::exe_out_t exps [8];
    logic                 vals [8];
    for (int i = 0; i < 8; i++) begin
      reqs[i] = make_req(ops[i], 3'($random(seed)), (i % 2) ? 7'h20 : 7'h00,
                         rand64(), rand64(), rand64(), rand64());
      reqs[i].memren = (ops[i] == `OPC_LOAD);
      reqs[i].memwen = (ops[i] == `OPC_STORE);
      vals[i] = (i != 6);  // One bubble in the stream
      exps[i] = ref_out(vals[i], reqs[i]);
    end
    for (int i = 0; i < 10; i++) begin
      @(posedge i_clk);
      #2;
      if (i >= 2) begin
        compare_out($sformatf("back_to_back[%0d]", i - 2), vals[i-2], exps[i-2]);
      end
      if (i < 8) begin
        i_valid = vals[i];
        i_req   = reqs[i];
      end else begin
        i_valid = 1'b0;
        i_req   = '0;
      end
    end
  endtask

  initial begin
    seed    = 30;
    i_reset = 1'b1;
    i_valid = 1'b0;
    i_req   = '0;
    repeat (3) @(posedge i_clk);
    #2;
    i_reset = 1'b0;
    test_reset();
    test_alu64();
    test_alu32();
    test_jumps();
    test_branches();
    test_back_to_back();
    $display("all tests passed");
    $finish;
  end

endmodule

//--- rv_exe.f
+incdir+common
common/rv_exe_pkg.sv
source/pipe_reg.sv
exe/alu_unit.sv
exe/branch_unit.sv
exe/exe_result_merge.sv
source/exe_top.sv
dv/exe_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module exe_tb -f rv_exe.f -o Vexe_tb

# The pipe keeps set -e from stopping here so the log decides
./obj_dir/Vexe_tb 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi

if ! grep -q "all tests passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation PASSED"
exit 0
